//--- keccak_rd_pkg.sv
// Shared widths, vector types and pipeline carriers for the Keccak state readout.
// NumShare may be 1 or 2. ShareIdxW must be wide enough to address NumShare shares.
// A word address is the word index in the low bits and the share index above it.

`default_nettype none

package keccak_rd_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int StateW    = 1600;
  localparam int WordW     = 32;
  localparam int NumShare  = 2;
  localparam int NumWord   = StateW / WordW;
  localparam int WordIdxW  = 6;
  localparam int ShareIdxW = 1;
  localparam int AddrW     = WordIdxW + ShareIdxW;

  // Vector types
  typedef logic [StateW-1:0] state_t;
  typedef logic [WordW-1:0]  word_t;
  typedef logic [AddrW-1:0]  word_addr_t;

  //////////////////////////////////////////////////
  // Pipeline carriers
  //////////////////////////////////////////////////

  // Request as seen by stage one
  typedef struct packed {
    word_addr_t addr;
    logic       we;
  } rd_req_t;

  // Stage one to stage two
  typedef struct packed {
    logic  valid;
    word_t word;
    logic  err;
    logic  swap;  // endian flag sampled with the request
  } rd_sel_t;

  // Response toward the top-level ports
  typedef struct packed {
    logic  valid;
    word_t data;
    logic  err;
  } rd_rsp_t;

endpackage

`default_nettype wire

//--- keccak_state_capture.sv
// Holds a snapshot of every share of the permutation state.
// A capture strobe at one edge is visible to reads sampled from the next edge on.
// The held state clears to zero on reset.

`timescale 1ns/1ps
`default_nettype none

module keccak_state_capture
  import keccak_rd_pkg::*;
(
  input  wire logic   clk_i,
  input  wire logic   rst_ni,

  // Strobe from the permutation core side
  input  wire logic   capture_i,
  input  wire state_t state_i [NumShare],

  // Frozen copy for the read path
  output state_t      state_o [NumShare]
);

  //////////////////////////////////////////////////
  // Snapshot registers
  //////////////////////////////////////////////////

  state_t state_q [NumShare];

  // All shares load together so the snapshot is consistent
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < NumShare; s++) begin
        state_q[s] <= '0;
      end
    end else if (capture_i) begin
      for (int s = 0; s < NumShare; s++) begin
        state_q[s] <= state_i[s];
      end
    end
  end

  // Read path sees only the held copy
  always_comb begin
    for (int s = 0; s < NumShare; s++) begin
      state_o[s] = state_q[s];
    end
  end

endmodule

`default_nettype wire

//--- keccak_word_select.sv
// First read stage. Slices one 32-bit word out of the held shares.
// Writes are refused here: error set, data zero.
// Word or share indices past the stored state read as zero without error.
// The endian flag is sampled with the request and carried to stage two.

`timescale 1ns/1ps
`default_nettype none

module keccak_word_select
  import keccak_rd_pkg::*;
(
  input  wire logic    clk_i,
  input  wire logic    rst_ni,

  input  wire logic    req_i,
  input  wire rd_req_t req_data_i,
  input  wire logic    endian_swap_i,
  input  wire state_t  state_i [NumShare],

  output rd_sel_t      sel_o
);

  //////////////////////////////////////////////////
  // Address decode and slicing
  //////////////////////////////////////////////////

  logic [ShareIdxW-1:0] share_idx;
  logic [WordIdxW-1:0]  word_idx;
  logic                 in_range;
  word_t                sel_word;
  rd_sel_t              sel_q;

  assign word_idx  = req_data_i.addr[WordIdxW-1:0];
  assign share_idx = req_data_i.addr[WordIdxW +: ShareIdxW];

  assign in_range = (int'(word_idx) < NumWord) && (int'(share_idx) < NumShare);

  // Loop over shares rather than index, so a missing share never indexes past the array
  always_comb begin
    sel_word = '0;
    if (!req_data_i.we && in_range) begin
      for (int s = 0; s < NumShare; s++) begin
        if (int'(share_idx) == s) begin
          sel_word = state_i[s][int'(word_idx)*WordW +: WordW];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Stage register
  //////////////////////////////////////////////////

  // Payload only loads with a request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q <= '0;
    end else begin
      sel_q.valid <= req_i;
      sel_q.err   <= req_i & req_data_i.we;
      if (req_i) begin
        sel_q.word <= sel_word;
        sel_q.swap <= endian_swap_i;
      end
    end
  end

  assign sel_o = sel_q;

endmodule

`default_nettype wire

//--- keccak_word_respond.sv
// Second read stage. Applies the byte order and registers the response.
// Data is forced to zero in any cycle without a valid response.
// Byte order is handled nowhere else in the read path.

`timescale 1ns/1ps
`default_nettype none

module keccak_word_respond
  import keccak_rd_pkg::*;
(
  input  wire logic    clk_i,
  input  wire logic    rst_ni,

  input  wire rd_sel_t sel_i,
  output rd_rsp_t      rsp_o
);

  // Reverse the four bytes when swap is set
  function automatic word_t byte_order(word_t w, logic swap);
    word_t res;
    res = w;
    if (swap) begin
      for (int b = 0; b < WordW/8; b++) begin
        res[b*8 +: 8] = w[(WordW/8-1-b)*8 +: 8];
      end
    end
    return res;
  endfunction

  //////////////////////////////////////////////////
  // Response register
  //////////////////////////////////////////////////

  rd_rsp_t rsp_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_q <= '0;
    end else begin
      rsp_q.valid <= sel_i.valid;
      rsp_q.err   <= sel_i.valid & sel_i.err;
      // Idle cycles drive zero data
      rsp_q.data  <= sel_i.valid ? byte_order(sel_i.word, sel_i.swap) : '0;
    end
  end

  assign rsp_o = rsp_q;

endmodule

`default_nettype wire

//--- keccak_state_reader.sv
// Keccak state readout, top level.
// One request per clock, response exactly two cycles later, no back-pressure.
// Writes return an error with zero data. No bus adapter: req_i is a plain strobe.

`timescale 1ns/1ps
`default_nettype none

module keccak_state_reader
  import keccak_rd_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,

  // State from the permutation core
  input  wire logic       capture_i,
  input  wire state_t     state_i [NumShare],

  // Read port
  input  wire logic       req_i,
  input  wire logic       we_i,
  input  wire word_addr_t addr_i,
  input  wire logic       endian_swap_i,

  output logic            rvalid_o,
  output word_t           rdata_o,
  output logic            err_o
);

  state_t  held_state [NumShare];
  rd_req_t req;
  rd_sel_t sel;
  rd_rsp_t rsp;

  assign req.addr = addr_i;
  assign req.we   = we_i;

  //////////////////////////////////////////////////
  // Capture, select, respond
  //////////////////////////////////////////////////

  keccak_state_capture u_capture (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .capture_i (capture_i),
    .state_i   (state_i),
    .state_o   (held_state)
  );

  keccak_word_select u_select (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_data_i    (req),
    .endian_swap_i (endian_swap_i),
    .state_i       (held_state),
    .sel_o         (sel)
  );

  keccak_word_respond u_respond (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .sel_i  (sel),
    .rsp_o  (rsp)
  );

  assign rvalid_o = rsp.valid;
  assign rdata_o  = rsp.data;
  assign err_o    = rsp.err;

endmodule

`default_nettype wire

//--- keccak_state_reader_properties.sv
// Concurrent checks for the Keccak state readout, bound to its top level.
// Latency is fixed at two cycles from the request edge.
// Reports only through failing assertions.

`timescale 1ns/1ps
`default_nettype none

module keccak_state_reader_properties
  import keccak_rd_pkg::*;
(
  input wire logic  clk_i,
  input wire logic  rst_ni,
  input wire logic  req_i,
  input wire logic  rvalid_o,
  input wire word_t rdata_o,
  input wire logic  err_o
);

  //////////////////////////////////////////////////
  // Latency
  //////////////////////////////////////////////////

  // Response exactly two edges after the request edge
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_o == $past(req_i, 2))
  else $error("rvalid_o does not follow req_i by two cycles");

  //////////////////////////////////////////////////
  // Reset and error behavior
  //////////////////////////////////////////////////

  assert property (@(posedge clk_i)
    !rst_ni |-> (!rvalid_o && !err_o && rdata_o == '0))
  else $error("outputs not idle during reset");

  // Refused writes carry no data
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_o |-> rdata_o == '0)
  else $error("err_o high with nonzero rdata_o");

endmodule

`default_nettype wire

//--- tb_keccak_state_reader.sv
// Self-checking testbench for the Keccak state readout.
// Keeps its own copy of the captured shares and predicts every response.
// Inputs change 2 ns after the rising edge. Responses are checked on the falling edge.
// Stops at the first error.

`timescale 1ns/1ps
`default_nettype none

module tb_keccak_state_reader
  import keccak_rd_pkg::*;
;

  localparam int ClkPeriod   = 20;
  localparam int ResetCycles = 10;
  localparam int NumMixReq   = 60;
  localparam int NumIsoReq   = 18;
  localparam int NumRandReq  = 400;
  localparam int CycleMargin = 4;
  localparam int PlannedReq  = 2 * NumShare * NumWord + (2 ** AddrW) + NumMixReq
                               + NumIsoReq + NumRandReq;

  // One predicted response
  typedef struct packed {
    word_addr_t  addr;
    word_t       data;
    logic        err;
    logic [31:0] cyc;
  } exp_t;

  logic       clk_i;
  logic       rst_ni;
  logic       capture_i;
  state_t     state_in [NumShare];
  logic       req_i;
  logic       we_i;
  word_addr_t addr_i;
  logic       endian_swap_i;
  logic       rvalid_o;
  word_t      rdata_o;
  logic       err_o;

  state_t      model_state [NumShare];
  exp_t        exp_q [$];
  logic [31:0] cycle_cnt;
  logic [31:0] rng_state;

  keccak_state_reader u_keccak_state_reader (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .capture_i     (capture_i),
    .state_i       (state_in),
    .req_i         (req_i),
    .we_i          (we_i),
    .addr_i        (addr_i),
    .endian_swap_i (endian_swap_i),
    .rvalid_o      (rvalid_o),
    .rdata_o       (rdata_o),
    .err_o         (err_o)
  );

  bind keccak_state_reader keccak_state_reader_properties u_properties (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (req_i),
    .rvalid_o (rvalid_o),
    .rdata_o  (rdata_o),
    .err_o    (err_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 32'd1;
  end

  //////////////////////////////////////////////////
  // Error reporting and compare tasks
  //////////////////////////////////////////////////

  task automatic stop_with_failure();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    stop_with_failure();
  endtask

  task automatic report_failure(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    stop_with_failure();
  endtask

  task automatic compare_word(input word_t got, input word_t exp, input word_addr_t addr);
    if (got !== exp) begin
      report_mismatch($sformatf("rdata for address 0x%02h is 0x%08h, expected 0x%08h",
                                addr, got, exp));
    end
  endtask

  task automatic compare_err(input logic got, input logic exp, input word_addr_t addr);
    if (got !== exp) begin
      report_mismatch($sformatf("err for address 0x%02h is %b, expected %b", addr, got, exp));
    end
  endtask

  //////////////////////////////////////////////////
  // Random numbers and reference model
  //////////////////////////////////////////////////

  // xorshift32
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic word_addr_t make_addr(input int unsigned share, input int unsigned word);
    return word_addr_t'((share << WordIdxW) | word);
  endfunction

  // Expected response from the readout rules
  function automatic exp_t expect_rsp(input word_addr_t addr, input logic we, input logic swap);
    exp_t        e;
    int unsigned share;
    int unsigned word;
    word_t       raw;
    share  = 32'(addr) >> WordIdxW;
    word   = 32'(addr) % (2 ** WordIdxW);
    raw    = '0;
    e      = '0;
    e.addr = addr;
    e.err  = we;
    if (!we && share < NumShare && word < NumWord) begin
      // Word k sits at bits 32k up to 32k+31
      raw = word_t'(model_state[share] >> (WordW * word));
    end
    e.data = swap ? {raw[7:0], raw[15:8], raw[23:16], raw[31:24]} : raw;
    return e;
  endfunction

  // New permutation state on the core side, not yet captured
  task automatic fill_random_state();
    for (int s = 0; s < NumShare; s++) begin
      for (int w = 0; w < NumWord; w++) begin
        state_in[s][w*WordW +: WordW] = next_rand();
      end
    end
  endtask

  task automatic take_snapshot();
    for (int s = 0; s < NumShare; s++) begin
      model_state[s] = state_in[s];
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic idle_cycles(input int n);
    req_i     = 1'b0;
    we_i      = 1'b0;
    capture_i = 1'b0;
    repeat (n) @(posedge clk_i);
    #2;
  endtask

  task automatic capture_state();
    capture_i = 1'b1;
    take_snapshot();
    @(posedge clk_i);
    #2;
    capture_i = 1'b0;
  endtask

  // One request; a capture in the same cycle is not yet visible to it
  task automatic drive_req(input logic we, input word_addr_t addr, input logic swap,
                           input logic cap);
    exp_t e;
    req_i         = 1'b1;
    we_i          = we;
    addr_i        = addr;
    endian_swap_i = swap;
    capture_i     = cap;
    e             = expect_rsp(addr, we, swap);
    e.cyc         = cycle_cnt + 32'd2;
    exp_q.push_back(e);
    if (cap) begin
      take_snapshot();
    end
    @(posedge clk_i);
    #2;
    req_i     = 1'b0;
    capture_i = 1'b0;
  endtask

  // Response checker
  always @(negedge clk_i) begin
    exp_t e;
    if (rst_ni && rvalid_o) begin
      if (exp_q.size() == 0) begin
        report_failure("rvalid_o came with no request outstanding");
      end else begin
        e = exp_q.pop_front();
        if (cycle_cnt !== e.cyc) begin
          report_mismatch($sformatf("response for address 0x%02h in cycle %0d, expected %0d",
                                    e.addr, cycle_cnt, e.cyc));
        end
        compare_word(rdata_o, e.data, e.addr);
        compare_err(err_o, e.err, e.addr);
      end
    end
  end

  initial begin
    repeat (ResetCycles + PlannedReq * CycleMargin) @(posedge clk_i);
    report_failure("watchdog expired before the tests finished");
  end

  initial begin
    int unsigned r;
    logic        sw;
    logic        cap;
    word_addr_t  a;
    rng_state     = 32'h3ed2_ee89;
    cycle_cnt     = '0;
    rst_ni        = 1'b0;
    capture_i     = 1'b0;
    req_i         = 1'b0;
    we_i          = 1'b0;
    addr_i        = '0;
    endian_swap_i = 1'b0;
    for (int s = 0; s < NumShare; s++) begin
      state_in[s]    = '0;
      model_state[s] = '0;
    end
    repeat (ResetCycles) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    idle_cycles(2);

    // Every word of every share, no swap
    fill_random_state();
    capture_state();
    for (int s = 0; s < NumShare; s++) begin
      for (int w = 0; w < NumWord; w++) begin
        drive_req(1'b0, make_addr(s, w), 1'b0, 1'b0);
      end
    end
    idle_cycles(3);

    // Swap flag toggles from one request to the next
    sw = 1'b1;
    for (int s = 0; s < NumShare; s++) begin
      for (int w = 0; w < NumWord; w++) begin
        drive_req(1'b0, make_addr(s, w), sw, 1'b0);
        sw = ~sw;
      end
    end
    idle_cycles(3);

    // Word and share indices past the stored state
    for (int s = 0; s < 2 ** ShareIdxW; s++) begin
      for (int w = 0; w < 2 ** WordIdxW; w++) begin
        if (s >= NumShare || w >= NumWord) begin
          r = next_rand();
          drive_req(1'b0, make_addr(s, w), r[0], 1'b0);
        end
      end
    end
    idle_cycles(3);

    // Writes mixed with reads
    for (int i = 0; i < NumMixReq; i++) begin
      r = next_rand();
      drive_req((r % 3) == 0, word_addr_t'(r >> 12), r[8], 1'b0);
    end
    idle_cycles(3);

    // Core state moves on without a capture
    fill_random_state();
    for (int i = 0; i < 8; i++) begin
      r = next_rand();
      drive_req(1'b0, make_addr(r % NumShare, (r >> 8) % NumWord), 1'b0, 1'b0);
    end
    a = make_addr(0, 7);
    drive_req(1'b0, a, 1'b0, 1'b1);
    drive_req(1'b0, a, 1'b0, 1'b0);
    for (int i = 0; i < 8; i++) begin
      r = next_rand();
      drive_req(1'b0, make_addr(r % NumShare, (r >> 8) % NumWord), r[3], 1'b0);
    end
    idle_cycles(3);

    // Long back-to-back stream with the odd capture
    for (int i = 0; i < NumRandReq; i++) begin
      r   = next_rand();
      cap = (r[31:27] == 5'd0);
      if (cap) begin
        fill_random_state();
      end
      drive_req((r % 4) == 0, word_addr_t'(r >> 8), r[2], cap);
    end
    idle_cycles(4);

    if (exp_q.size() != 0) begin
      $display("Error at %0t ns: %0d responses never arrived", $time, exp_q.size());
      stop_with_failure();
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- keccak_state_reader.f
keccak_rd_pkg.sv
keccak_state_capture.sv
keccak_word_select.sv
keccak_word_respond.sv
keccak_state_reader.sv
keccak_state_reader_properties.sv
tb_keccak_state_reader.sv

//--- Makefile
# Verilator build and run of the Keccak state readout testbench

VERILATOR ?= verilator
TOP       ?= tb_keccak_state_reader
FILELIST  ?= keccak_state_reader.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "RESULT: FAIL" $(LOG) || [ $$status -ne 0 ]; then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
